// File: rtl/gateway_cfg.svh
`ifndef GATEWAY_CFG_SVH
`define GATEWAY_CFG_SVH

// Cycles from a bus strobe to valid read data at the bank output
`define GW_READ_PIPE_LEN 3

// Cycles from a byte at idata to the same byte slot at odata
// Must be at least 5 plus the read pipe length
`define GW_N_LAT 8

// Low address bits decoded by the register bank
// 4 bits give 16 registers, higher bits alias onto them
`define GW_REG_ADDR_BITS 4

`endif

// File: rtl/gateway_pkg.sv
// Types shared by the gateway datapath and its register bank
// Network byte order throughout, so the first byte on the wire is the MSB
package gateway_pkg;

	// One payload byte as it arrives from the UDP client
	typedef logic [7:0] byte_t;

	// Control-and-address word, the first half of a command pair
	// Only the read flag and the 24-bit address carry meaning
	typedef struct packed {
		logic [2:0]  spare_hi;
		logic        rd;
		logic [3:0]  spare_lo;
		logic [23:0] addr;
	} ctrl_word_t;

	// Full 8-byte command pair as it sits in the input shift register
	// Control word was received first, so it lands in the upper half
	typedef struct packed {
		ctrl_word_t  ctrl;
		logic [31:0] data;
	} cmd_pair_t;

	// Local bus command handed from the parser to the register bank
	// Held stable between strobes
	typedef struct packed {
		logic [23:0] addr;
		logic        rd;
		logic [31:0] wdata;
	} bus_cmd_t;

	// Four bytes of a 32-bit word, index 3 is the byte sent first
	typedef byte_t [3:0] word_bytes_t;

endpackage

// File: rtl/byte_delay.sv
`timescale 1ns/1ns

// Fixed-length delay line
// Payload type is a parameter so one block serves bytes, words and flags
// Length zero degenerates to a plain connection
module byte_delay #(
	parameter type payload_t = logic [7:0],
	parameter int  len = 1
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t din,
	output payload_t dout
);

	generate
		if (len == 0) begin : g_bypass
			// No stages requested
			assign dout = din;
		end else begin : g_chain
			// Stage 0 takes din, stage len-1 feeds dout
			payload_t stages [len];

			always_ff @(posedge clk) begin
				if (rst) begin
					for (int i = 0; i < len; i++) begin
						stages[i] <= '0;
					end
				end else begin
					stages[0] <= din;
					// Every stage advances every cycle, no gating
					for (int i = 1; i < len; i++) begin
						stages[i] <= stages[i-1];
					end
				end
			end

			assign dout = stages[len-1];
		end
	endgenerate

endmodule

// File: rtl/command_parser.sv
`timescale 1ns/1ns

// Turns the payload byte stream into local bus commands
// Layout: 8 bytes of padding, then 8-byte command pairs
// Each pair is a control+address word followed by a data word
module command_parser (
	input  logic                  clk,
	input  logic                  rst,
	input  gateway_pkg::byte_t    idata,
	input  logic                  raw_s,
	output gateway_pkg::bus_cmd_t cmd,
	output logic                  cmd_strobe
);

	// Last eight bytes seen, newest in the low byte
	logic [63:0] isr;
	// Shift register contents including the current byte
	logic [63:0] next_isr;
	// Position of the current byte inside its 8-byte group
	logic [2:0] byte_cnt;
	// High once the padding group has gone by
	logic body;
	// Current byte closes a command pair
	logic pair_done;
	// Current eight bytes seen as a command pair
	gateway_pkg::cmd_pair_t pair;

	assign next_isr = {isr[55:0], idata};
	assign pair = gateway_pkg::cmd_pair_t'(next_isr);

	// Only a byte that is really part of the packet may complete a pair,
	// so a trailing partial pair never reaches the bus
	assign pair_done = raw_s & body & (&byte_cnt);

	always_ff @(posedge clk) begin
		if (rst) begin
			isr <= '0;
			byte_cnt <= '0;
			body <= 1'b0;
		end else begin
			// Shifts unconditionally, stale bytes are never used
			isr <= next_isr;

			// Counter restarts at each packet
			if (raw_s) begin
				byte_cnt <= byte_cnt + 3'd1;
			end else begin
				byte_cnt <= '0;
			end

			// Body starts after the eighth padding byte
			if (!raw_s) begin
				body <= 1'b0;
			end else if (&byte_cnt) begin
				body <= 1'b1;
			end
		end
	end

	// Command register and strobe, one cycle after the last pair byte
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd <= '0;
			cmd_strobe <= 1'b0;
		end else begin
			cmd_strobe <= pair_done;
			// Held until the next pair completes
			if (pair_done) begin
				cmd.addr <= pair.ctrl.addr;
				cmd.rd <= pair.ctrl.rd;
				cmd.wdata <= pair.data;
			end
		end
	end

endmodule

// File: rtl/register_bank.sv
`timescale 1ns/1ns

`include "gateway_cfg.svh"

// Local bus target
// Bank of 32-bit registers, only the low address bits are decoded
// Reads return after a fixed pipe, no wait states
module register_bank (
	input  logic                  clk,
	input  logic                  rst,
	input  gateway_pkg::bus_cmd_t cmd,
	input  logic                  cmd_strobe,
	output logic [31:0]           rdata,
	output logic                  rd_valid
);

	localparam int ADDR_BITS = `GW_REG_ADDR_BITS;
	localparam int N_REGS = 1 << ADDR_BITS;

	logic [31:0] regs [N_REGS];
	// Decoded register index, upper address bits alias
	logic [ADDR_BITS-1:0] idx;
	// First read stage, value sampled at the strobe
	logic [31:0] rd_word;
	logic rd_flag;
	logic do_write;
	logic do_read;

	assign idx = cmd.addr[ADDR_BITS-1:0];
	assign do_write = cmd_strobe & ~cmd.rd;
	assign do_read = cmd_strobe & cmd.rd;

	// Write lands at the edge closing the strobe cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < N_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (do_write) begin
			regs[idx] <= cmd.wdata;
		end
	end

	// Read sample taken at the same edge, then carried down the pipe
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_word <= '0;
			rd_flag <= 1'b0;
		end else begin
			rd_flag <= do_read;
			if (do_read) begin
				rd_word <= regs[idx];
			end
		end
	end

	// Remaining stages so data and flag arrive together
	byte_delay #(
		.payload_t(logic [31:0]),
		.len(`GW_READ_PIPE_LEN - 1)
	) i_word_pipe (
		.clk(clk),
		.rst(rst),
		.din(rd_word),
		.dout(rdata)
	);

	byte_delay #(
		.payload_t(logic),
		.len(`GW_READ_PIPE_LEN - 1)
	) i_flag_pipe (
		.clk(clk),
		.rst(rst),
		.din(rd_flag),
		.dout(rd_valid)
	);

endmodule

// File: rtl/reply_merge.sv
`timescale 1ns/1ns

// Output shift register for the reply stream
// Echoed bytes pass through four byte slots
// A read result overwrites the slots in one go
module reply_merge (
	input  logic               clk,
	input  logic               rst,
	input  gateway_pkg::byte_t pdata,
	input  logic [31:0]        rdata,
	input  logic               rd_valid,
	output gateway_pkg::byte_t xdata
);

	// Slot 3 leaves next, slot 0 takes the newest byte
	gateway_pkg::word_bytes_t osr;

	always_ff @(posedge clk) begin
		if (rst) begin
			osr <= '0;
		end else if (rd_valid) begin
			// rd_valid coincides with the last data byte of the read pair,
			// so the four data bytes still queued here are replaced
			osr <= gateway_pkg::word_bytes_t'(rdata);
		end else begin
			osr <= {osr[2:0], pdata};
		end
	end

	// MSB of a loaded word goes out first, matching network order
	assign xdata = osr[3];

endmodule

// File: rtl/mem_gateway_top.sv
`timescale 1ns/1ns

`include "gateway_cfg.svh"

// UDP payload to local bus gateway with its register bank
// Every byte comes back GW_N_LAT cycles later, read data filled in
module mem_gateway_top (
	input  logic               clk,
	input  logic               rst,
	input  gateway_pkg::byte_t idata,
	input  logic               raw_s,
	output gateway_pkg::byte_t odata
);

	// Parser to bank
	gateway_pkg::bus_cmd_t cmd;
	logic cmd_strobe;

	// Bank to merge
	logic [31:0] rdata;
	logic rd_valid;

	// Payload aligned to the read result
	gateway_pkg::byte_t pdata;
	// Payload with read data substituted
	gateway_pkg::byte_t xdata;

	command_parser i_parser (
		.clk(clk),
		.rst(rst),
		.idata(idata),
		.raw_s(raw_s),
		.cmd(cmd),
		.cmd_strobe(cmd_strobe)
	);

	register_bank i_bank (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.cmd_strobe(cmd_strobe),
		.rdata(rdata),
		.rd_valid(rd_valid)
	);

	// One cycle for the strobe plus the read pipe
	byte_delay #(
		.payload_t(gateway_pkg::byte_t),
		.len(`GW_READ_PIPE_LEN + 1)
	) i_align (
		.clk(clk),
		.rst(rst),
		.din(idata),
		.dout(pdata)
	);

	reply_merge i_merge (
		.clk(clk),
		.rst(rst),
		.pdata(pdata),
		.rdata(rdata),
		.rd_valid(rd_valid),
		.xdata(xdata)
	);

	// Pads the path out to the configured total latency
	// 4 merge slots plus 1 strobe cycle are already spent
	byte_delay #(
		.payload_t(gateway_pkg::byte_t),
		.len(`GW_N_LAT - `GW_READ_PIPE_LEN - 5)
	) i_finale (
		.clk(clk),
		.rst(rst),
		.din(xdata),
		.dout(odata)
	);

endmodule

// File: verification/gateway_checker.sv
`timescale 1ns/1ns

`include "gateway_cfg.svh"

// Watches the gateway ports and predicts every odata byte
// Keeps its own register mirror and packet position
module gateway_checker (
	input  logic               clk,
	input  logic               rst,
	input  gateway_pkg::byte_t idata,
	input  logic               raw_s,
	input  gateway_pkg::byte_t odata,
	output int                 checks,
	output int                 errors
);

	localparam int N_REGS = 1 << `GW_REG_ADDR_BITS;

	// Expected odata bytes, the front one is due at this edge
	gateway_pkg::byte_t exp_q [$];
	// Register contents the bus target should hold
	logic [31:0] mirror [N_REGS];
	// Count of packet bytes seen so far in the current packet
	int pos;
	// Last eight packet bytes, newest in the low byte
	logic [63:0] window;

	// Applies the packet layout to one input byte
	// Returns 1 when the byte closes a read pair, word then holds the register value
	function automatic logic model_byte(input gateway_pkg::byte_t b, input logic s,
			output logic [31:0] word);
		logic [31:0] ctrl;
		logic [`GW_REG_ADDR_BITS-1:0] idx;
		word = '0;
		// Idle cycle ends the packet, a partial pair is dropped
		if (!s) begin
			pos = 0;
			return 1'b0;
		end
		window = {window[55:0], b};
		pos++;
		// 8 padding bytes, then a pair closes on every eighth byte
		if (pos < 16 || pos % 8 != 0) begin
			return 1'b0;
		end
		ctrl = window[63:32];
		idx = ctrl[`GW_REG_ADDR_BITS-1:0];
		// Bit 28 is the read flag
		if (ctrl[28]) begin
			word = mirror[idx];
			return 1'b1;
		end
		mirror[idx] = window[31:0];
		return 1'b0;
	endfunction

	always @(posedge clk) begin : compare
		gateway_pkg::byte_t expected;
		logic [31:0] word;
		if (rst) begin
			// Delay lines hold zeros right after reset
			exp_q = {};
			repeat (`GW_N_LAT) exp_q.push_back(8'h00);
			for (int i = 0; i < N_REGS; i++) begin
				mirror[i] = '0;
			end
			pos = 0;
			window = '0;
			checks = 0;
			errors = 0;
		end else begin
			if (exp_q.size() == 0) begin
				$display("Error: no expected byte left for odata at %0t", $time);
				errors++;
			end else begin
				expected = exp_q.pop_front();
				checks++;
				if (odata !== expected) begin
					$display("Fail odata at %0t: expected %h, got %h", $time, expected, odata);
					errors++;
				end
			end
			// Echo by default, idle bytes included
			exp_q.push_back(idata);
			if (model_byte(idata, raw_s, word)) begin
				// The four data bytes just queued become the read value, MSB first
				for (int k = 0; k < 4; k++) begin
					exp_q[exp_q.size() - 4 + k] = word[31 - 8 * k -: 8];
				end
			end
		end
	end

endmodule

// File: verification/gateway_tb.sv
`timescale 1ns/1ns

`include "gateway_cfg.svh"

module gateway_tb;

	localparam int N_RAND = 40;
	// Packets sent by the directed tests
	localparam int N_DIRECTED = 6;
	localparam int N_TESTS = 5;
	// Padding, 16 pairs, a partial pair and the longest gap
	localparam int MAX_PKT_CYCLES = 8 + 16 * 8 + 7 + 6;
	localparam int WATCHDOG_CYCLES = (N_RAND + N_DIRECTED) * MAX_PKT_CYCLES
		+ N_TESTS * (`GW_N_LAT + 2) + 200;

	logic clk = 1'b0;
	logic rst;
	gateway_pkg::byte_t idata;
	logic raw_s;
	gateway_pkg::byte_t odata;
	int checks;
	int errors;

	logic [31:0] lfsr = 32'h2936e84f;
	// Bytes of the packet being built
	gateway_pkg::byte_t pkt [$];
	int test_no = 0;
	int last_checks = 0;
	int last_errors = 0;

	always #5 clk = ~clk;

	// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	// Random upper bits with the chosen register in the low bits
	function automatic logic [23:0] addr_of(input int reg_no);
		logic [23:0] a;
		a = 24'(rand_bits(24));
		a[`GW_REG_ADDR_BITS-1:0] = reg_no[`GW_REG_ADDR_BITS-1:0];
		return a;
	endfunction

	task automatic add_padding();
		for (int i = 0; i < 8; i++) begin
			pkt.push_back(8'(rand_bits(8)));
		end
	endtask

	// Control word then data word in big endian order with random spare bits
	task automatic add_cmd(input logic rd, input logic [23:0] addr, input logic [31:0] data);
		logic [6:0] spare;
		logic [31:0] ctrl;
		spare = 7'(rand_bits(7));
		ctrl = {spare[6:4], rd, spare[3:0], addr};
		for (int i = 3; i >= 0; i--) begin
			pkt.push_back(ctrl[8 * i +: 8]);
		end
		for (int i = 3; i >= 0; i--) begin
			pkt.push_back(data[8 * i +: 8]);
		end
	endtask

	// Drives the packet and then holds raw_s low for the gap
	task automatic send_packet(input int gap);
		foreach (pkt[i]) begin
			@(negedge clk);
			idata = pkt[i];
			raw_s = 1'b1;
		end
		repeat (gap) begin
			@(negedge clk);
			idata = '0;
			raw_s = 1'b0;
		end
		pkt = {};
	endtask

	// Lets the last bytes leave the fixed latency and then reports
	task automatic end_test(input string name);
		repeat (`GW_N_LAT + 2) @(negedge clk);
		test_no++;
		if (errors == last_errors) begin
			$display("Test %0d %s: passed, %0d bytes checked", test_no, name,
				checks - last_checks);
		end else begin
			$display("Test %0d %s: failed, %0d errors", test_no, name, errors - last_errors);
		end
		last_checks = checks;
		last_errors = errors;
	endtask

	initial begin
		logic [23:0] a;
		logic rd_bit;
		int reg_no;
		int n_pairs;
		int n_tail;
		rst = 1'b1;
		raw_s = 1'b0;
		idata = '0;
		// Random bytes while reset holds so only cleared delay lines give a quiet odata
		repeat (8) begin
			@(negedge clk);
			idata = 8'(rand_bits(8));
		end
		rst = 1'b0;
		idata = '0;

		// Quiet odata after reset and reads of untouched registers
		add_padding();
		for (int r = 0; r < 16; r++) begin
			add_cmd(1'b1, addr_of(r), rand_bits(32));
		end
		send_packet(2);
		end_test("reset_and_unwritten_reads");

		// Writes to every register with all bytes echoed
		for (int p = 0; p < 2; p++) begin
			add_padding();
			for (int r = 0; r < 8; r++) begin
				add_cmd(1'b0, addr_of(8 * p + r), rand_bits(32));
			end
			send_packet(1);
		end
		end_test("padding_and_write_echo");

		// Read back in the same packet and every register from a later packet
		add_padding();
		add_cmd(1'b0, addr_of(5), 32'ha1b2c3d4);
		add_cmd(1'b1, addr_of(5), rand_bits(32));
		send_packet(1);
		add_padding();
		for (int r = 0; r < 16; r++) begin
			add_cmd(1'b1, addr_of(r), rand_bits(32));
		end
		send_packet(3);
		end_test("write_then_read");

		// Flipped upper address bits must reach the same register
		a = addr_of(9);
		add_padding();
		add_cmd(1'b0, a, 32'h5e6f7081);
		add_cmd(1'b1, a ^ 24'h800010, rand_bits(32));
		add_cmd(1'b1, a ^ 24'h0fff00, rand_bits(32));
		send_packet(1);
		end_test("address_aliasing");

		for (int p = 0; p < N_RAND; p++) begin
			add_padding();
			n_pairs = int'(rand_bits(3));
			for (int c = 0; c < n_pairs; c++) begin
				rd_bit = 1'(rand_bits(1));
				reg_no = int'(rand_bits(4));
				add_cmd(rd_bit, addr_of(reg_no), rand_bits(32));
			end
			// Some packets stop inside a pair that is only echoed
			n_tail = int'(rand_bits(3));
			for (int b = 0; b < n_tail; b++) begin
				pkt.push_back(8'(rand_bits(8)));
			end
			send_packet(1 + int'(rand_bits(3)) % 6);
		end
		end_test("random_back_to_back");

		$display("Tests: %0d, bytes checked: %0d, errors: %0d", test_no, checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	mem_gateway_top i_dut (
		.clk(clk),
		.rst(rst),
		.idata(idata),
		.raw_s(raw_s),
		.odata(odata)
	);

	gateway_checker i_checker (
		.clk(clk),
		.rst(rst),
		.idata(idata),
		.raw_s(raw_s),
		.odata(odata),
		.checks(checks),
		.errors(errors)
	);

endmodule

// File: list.f
+incdir+rtl
rtl/gateway_pkg.sv
rtl/byte_delay.sv
rtl/command_parser.sv
rtl/register_bank.sv
rtl/reply_merge.sv
rtl/mem_gateway_top.sv
verification/gateway_checker.sv
verification/gateway_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= gateway_tb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
PASS_MSG ?= Done: no errors

SRCS := $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
